// ==== Makefile ====
TOP = vec_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== bench/vec_unit_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_unit_chk (
  input wire logic                    CLK,
  input wire logic                    nRST,
  input wire logic                    hold,
  input wire logic                    busy,
  input wire logic                    done,
  input wire logic                    wb_en,
  input wire vec_cfg_pkg::lane_mask_t wb_mask
);

  // number of assertion failures so far, the testbench reads it
  int unsigned fail_count = 0;

  // a frozen pipeline writes nothing back
  wb_quiet_in_hold: assert property (@(posedge CLK) disable iff (!nRST) hold |-> !wb_en)
    else begin
      fail_count++;
      $error("write-back seen while hold is high");
    end

  // an instruction that ran groups ends together with its last write-back
  done_with_wb: assert property (@(posedge CLK) disable iff (!nRST) (done && busy) |-> wb_en)
    else begin
      fail_count++;
      $error("done without a write-back in the same cycle");
    end

  // every group that reaches write-back carries at least one live lane
  wb_mask_live: assert property (@(posedge CLK) disable iff (!nRST) wb_en |-> (wb_mask != '0))
    else begin
      fail_count++;
      $error("write-back with an all-zero lane mask");
    end

  // the unit is free again on the edge after done
  busy_drop: assert property (@(posedge CLK) disable iff (!nRST) (done && busy) |=> !busy)
    else begin
      fail_count++;
      $error("busy still high one cycle after done");
    end

endmodule

bind vec_unit_top vec_unit_chk i_vec_unit_chk (
  .CLK     (CLK),
  .nRST    (nRST),
  .hold    (hold),
  .busy    (busy),
  .done    (done),
  .wb_en   (wb_en),
  .wb_mask (wb_mask)
);

`default_nettype wire

// ==== bench/vec_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_unit_tb;
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_RANDOM = 16;
  // fixed tests plus read-backs plus the random ones
  localparam int NUM_INSTR = 17 + NUM_RANDOM;
  // each instruction gets VLMAX+10 cycles, preload and reset come on top
  localparam int WATCHDOG_CYCLES = NUM_INSTR * (VLMAX + 10) + NUM_VREGS * VLMAX + 200;

  // one expected write-back group
  typedef struct {
    vreg_t      rg;
    offset_t    offset;
    group_t     data;
    lane_mask_t mask;
    logic       last;
  } wb_exp_t;

  logic       CLK = 1'b0;
  logic       nRST;
  logic       start;
  logic       hold;
  logic       clear;
  vec_op_e    op;
  vreg_t      vd;
  vreg_t      vs1;
  vreg_t      vs2;
  offset_t    vl;
  offset_t    vstart;
  logic       load_en;
  vreg_t      load_reg;
  offset_t    load_index;
  group_t     load_data;
  logic       busy;
  logic       done;
  logic       wb_en;
  vreg_t      wb_reg;
  offset_t    wb_offset;
  group_t     wb_data;
  lane_mask_t wb_mask;

  // model of the register file, follows loads and matched write-backs
  elem_t       model_mem [NUM_VREGS][VLMAX];
  wb_exp_t     exp_q[$];
  string       test_name = "reset";
  logic [31:0] lcg_state = 32'h80c0ec58;
  logic        done_seen = 1'b0;
  logic        empty_expected = 1'b0;
  logic        done_last_cycle = 1'b0;
  logic        hold_seen = 1'b0;
  int          cyc = 0;
  int          start_cyc = 0;
  int          grp_idx = 0;
  int          wb_count = 0;

  vec_unit_top i_vec_unit_top (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  task automatic report_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(int unsigned n);
    return int'((lcg_next() >> 8) % n);
  endfunction

  task automatic check_elem(string what, elem_t exp, elem_t act);
    if (exp !== act) begin
      $display("Error: %s: %s expected %h actual %h", test_name, what, exp, act);
      report_failure();
    end
  endtask

  task automatic check_mask(string what, lane_mask_t exp, lane_mask_t act);
    if (exp !== act) begin
      $display("Error: %s: %s expected %b actual %b", test_name, what, exp, act);
      report_failure();
    end
  endtask

  task automatic check_offset(string what, offset_t exp, offset_t act);
    if (exp !== act) begin
      $display("Error: %s: %s expected %0d actual %0d", test_name, what, exp, act);
      report_failure();
    end
  endtask

  task automatic check_reg(string what, vreg_t exp, vreg_t act);
    if (exp !== act) begin
      $display("Error: %s: %s expected v%0d actual v%0d", test_name, what, exp, act);
      report_failure();
    end
  endtask

  // expected group at offset k, lane i lives while k+i stays below vl
  function automatic wb_exp_t ref_group(vec_op_e o, vreg_t d, vreg_t s1, vreg_t s2,
                                        int vl_eff, int k);
    wb_exp_t e;
    e.rg     = d;
    e.offset = offset_t'(k);
    e.data   = '0;
    e.mask   = '0;
    e.last   = (k + NUM_LANES >= vl_eff);
    for (int i = 0; i < NUM_LANES; i++) begin
      if (k + i < vl_eff) begin
        e.mask[i] = 1'b1;
        e.data[i*ELEM_W +: ELEM_W] = vec_elem_op(o, model_mem[s1][k+i], model_mem[s2][k+i]);
      end
    end
    return e;
  endfunction

  // all groups are disjoint, so the whole queue can be built from the old contents
  task automatic push_expected(vec_op_e o, vreg_t d, vreg_t s1, vreg_t s2,
                               offset_t l, offset_t vs);
    int vl_eff;
    int k;
    vl_eff = (int'(l) > VLMAX) ? VLMAX : int'(l);
    k = int'(vs);
    while (k < vl_eff) begin
      exp_q.push_back(ref_group(o, d, s1, s2, vl_eff, k));
      k = k + NUM_LANES;
    end
    empty_expected = (int'(vs) >= vl_eff);
    done_seen = 1'b0;
  endtask

  task automatic drive_start(vec_op_e o, vreg_t d, vreg_t s1, vreg_t s2,
                             offset_t l, offset_t vs);
    @(posedge CLK);
    start  <= 1'b1;
    op     <= o;
    vd     <= d;
    vs1    <= s1;
    vs2    <= s2;
    vl     <= l;
    vstart <= vs;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // runs one instruction to its done, with optional random hold
  // poke sends a second start while busy, which the DUT must drop
  task automatic run_instr(vec_op_e o, vreg_t d, vreg_t s1, vreg_t s2, offset_t l,
                           offset_t vs, int hold_pct, logic poke);
    int n;
    push_expected(o, d, s1, s2, l, vs);
    drive_start(o, d, s1, s2, l, vs);
    n = 0;
    while (!done_seen) begin
      @(posedge CLK);
      hold  <= (rand_range(100) < hold_pct);
      start <= poke && (n == 2);
      if (poke && n == 2) begin
        op <= VXOR;
        vd <= d + 3'd1;
      end
      n++;
    end
    hold  <= 1'b0;
    start <= 1'b0;
    @(negedge CLK);
    while (busy) @(negedge CLK);
  endtask

  task automatic read_back(vreg_t r);
    run_instr(VOR, 3'd7, r, r, 5'd16, 5'd0, 0, 1'b0);
  endtask

  task automatic load_group(vreg_t r, offset_t idx, group_t data);
    @(posedge CLK);
    load_en    <= 1'b1;
    load_reg   <= r;
    load_index <= idx;
    load_data  <= data;
    for (int i = 0; i < NUM_LANES; i++) begin
      model_mem[r][int'(idx) + i] = data[i*ELEM_W +: ELEM_W];
    end
  endtask

  // compare process, outputs are sampled on the falling edge where they are settled
  always @(negedge CLK) begin
    wb_exp_t e;
    cyc++;
    if (nRST) begin
      if (i_vec_unit_top.i_vec_unit_chk.fail_count != 0) begin
        $display("Error: %s: a bound assertion on the top level failed", test_name);
        report_failure();
      end
      if (done_last_cycle && busy) begin
        $display("Error: %s: busy is still high one cycle after done", test_name);
        report_failure();
      end
      done_last_cycle = 1'b0;
      // an accepted start marks cycle zero of the instruction
      if (start && !busy) begin
        start_cyc = cyc;
        grp_idx   = 0;
        hold_seen = 1'b0;
      end
      if (hold) hold_seen = 1'b1;
      if (wb_en) begin
        if (hold) begin
          $display("Error: %s: write-back while hold is high", test_name);
          report_failure();
        end
        if (exp_q.size() == 0) begin
          $display("Error: %s: unexpected write-back to v%0d at offset %0d",
                   test_name, wb_reg, wb_offset);
          report_failure();
        end
        e = exp_q.pop_front();
        check_reg("wb_reg", e.rg, wb_reg);
        check_offset("wb_offset", e.offset, wb_offset);
        check_mask("wb_mask", e.mask, wb_mask);
        for (int i = 0; i < NUM_LANES; i++) begin
          if (e.mask[i]) begin
            check_elem($sformatf("lane %0d data", i), e.data[i*ELEM_W +: ELEM_W],
                       elem_t'(wb_data[i*ELEM_W +: ELEM_W]));
            model_mem[e.rg][int'(e.offset) + i] = e.data[i*ELEM_W +: ELEM_W];
          end
        end
        // counter holds k one cycle after start, rd_valid one later, then two stages
        if (!hold_seen && cyc != start_cyc + 4 + grp_idx) begin
          $display("Error: %s: group %0d expected in cycle %0d actual %0d",
                   test_name, grp_idx, start_cyc + 4 + grp_idx, cyc);
          report_failure();
        end
        grp_idx++;
        wb_count++;
        if (done !== e.last) begin
          $display("Error: %s: done expected %b actual %b", test_name, e.last, done);
          report_failure();
        end
        if (done) begin
          done_seen       = 1'b1;
          done_last_cycle = 1'b1;
        end
      end else if (done) begin
        if (!empty_expected) begin
          $display("Error: %s: done arrived without its last write-back", test_name);
          report_failure();
        end
        if (busy || cyc != start_cyc + 1) begin
          $display("Error: %s: empty instruction should finish one cycle after start",
                   test_name);
          report_failure();
        end
        empty_expected = 1'b0;
        done_seen      = 1'b1;
      end
      // whatever was left of the instruction is abandoned
      if (clear) exp_q.delete();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Error: watchdog expired after %0d cycles, the DUT stopped answering",
             WATCHDOG_CYCLES);
    report_failure();
  end

  initial begin
    int      n0;
    vec_op_e r_op;
    vreg_t   r_vd;
    vreg_t   r_s1;
    vreg_t   r_s2;
    offset_t r_vl;
    offset_t r_vs;
    nRST       = 1'b0;
    start      = 1'b0;
    hold       = 1'b0;
    clear      = 1'b0;
    op         = VADD;
    vd         = '0;
    vs1        = '0;
    vs2        = '0;
    vl         = '0;
    vstart     = '0;
    load_en    = 1'b0;
    load_reg   = '0;
    load_index = '0;
    load_data  = '0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;

    test_name = "preload";
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int g = 0; g < VLMAX; g += NUM_LANES) begin
        load_group(vreg_t'(r), offset_t'(g), group_t'(lcg_next()));
      end
    end
    @(posedge CLK);
    load_en <= 1'b0;

    test_name = "full_length";
    for (int o = 0; o < 6; o++) begin
      run_instr(vec_op_e'(o), 3'd6, 3'd1, 3'd2, 5'd16, 5'd0, 0, 1'b0);
    end

    // element 7 of v5 must keep its preloaded value
    test_name = "odd_vl";
    run_instr(VADD, 3'd5, 3'd1, 3'd2, 5'd7, 5'd0, 0, 1'b0);
    read_back(3'd5);

    test_name = "vstart";
    run_instr(VXOR, 3'd4, 3'd2, 3'd3, 5'd16, 5'd6, 0, 1'b0);
    run_instr(VSUB, 3'd4, 3'd3, 3'd1, 5'd11, 5'd5, 0, 1'b0);
    read_back(3'd4);
    run_instr(VADD, 3'd4, 3'd1, 3'd1, 5'd8, 5'd8, 0, 1'b0);
    run_instr(VADD, 3'd4, 3'd1, 3'd1, 5'd5, 5'd12, 0, 1'b0);

    // odd runs use random hold, even runs also check the fixed latency
    test_name = "random_hold";
    for (int j = 0; j < NUM_RANDOM; j++) begin
      r_op = vec_op_e'(rand_range(6));
      r_vd = vreg_t'(rand_range(NUM_VREGS));
      r_s1 = vreg_t'(rand_range(NUM_VREGS));
      r_s2 = vreg_t'(rand_range(NUM_VREGS));
      r_vl = offset_t'(rand_range(21));
      r_vs = (rand_range(4) == 0) ? offset_t'(rand_range(18)) : offset_t'(rand_range(4));
      run_instr(r_op, r_vd, r_s1, r_s2, r_vl, r_vs, (j % 2 == 1) ? 30 : 0, 1'b0);
    end

    test_name = "vd_eq_vs1";
    run_instr(VADD, 3'd3, 3'd3, 3'd2, 5'd16, 5'd0, 0, 1'b1);
    read_back(3'd3);

    test_name = "clear";
    push_expected(VADD, 3'd6, 3'd1, 3'd2, 5'd16, 5'd0);
    drive_start(VADD, 3'd6, 3'd1, 3'd2, 5'd16, 5'd0);
    n0 = wb_count;
    while (wb_count < n0 + 2) @(posedge CLK);
    clear <= 1'b1;
    @(posedge CLK);
    clear <= 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    if (busy || done_seen) begin
      $display("Error: %s: instruction still running or finished after clear", test_name);
      report_failure();
    end
    run_instr(VSUB, 3'd6, 3'd6, 3'd1, 5'd16, 5'd0, 0, 1'b0);

    @(negedge CLK);
    if (i_vec_unit_top.i_vec_unit_chk.fail_count == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Error: a bound assertion on the top level failed");
      report_failure();
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/vec_cfg_pkg.sv
src/vec_op_pkg.sv
src/element_counter.sv
src/vec_issue.sv
src/vec_regfile.sv
src/vec_lane_alu.sv
src/vec_unit_top.sv
bench/vec_unit_chk.sv
bench/vec_unit_tb.sv

// ==== src/element_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module element_counter (
  input  wire logic                 CLK,
  input  wire logic                 nRST,
  input  wire logic                 clear,
  input  wire logic                 start,
  input  wire logic                 advance,
  input  wire vec_cfg_pkg::offset_t vl,
  input  wire vec_cfg_pkg::offset_t vstart,
  output vec_cfg_pkg::offset_t      offset,
  output logic                      last,
  output logic                      active
);
  import vec_cfg_pkg::*;

  // one extra bit so that offset plus the step never wraps
  logic [$bits(offset_t):0] group_end;

  assign group_end = {1'b0, offset} + ($bits(offset_t)+1)'(NUM_LANES);

  // the current group is the final one when it reaches or passes vl
  assign last = active & (group_end >= {1'b0, vl});

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      offset <= '0;
      active <= 1'b0;
    end else if (clear) begin
      // an abandoned instruction leaves no group behind
      offset <= '0;
      active <= 1'b0;
    end else if (start) begin
      // restart point, a vstart at or past vl means nothing to issue
      offset <= vstart;
      active <= (vstart < vl);
    end else if (active && advance) begin
      if (last) begin
        offset <= '0;
        active <= 1'b0;
      end else begin
        offset <= offset + offset_t'(NUM_LANES);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/vec_cfg_pkg.sv ====
`default_nettype none

package vec_cfg_pkg;

  // number of elements that are handled side by side in one cycle
  localparam int NUM_LANES = 2;

  // elements held by one vector register, also the upper bound for vl
  localparam int VLMAX = 16;

  // size of the architectural vector register bank
  localparam int NUM_VREGS = 8;

  // only 16-bit elements are supported by this unit
  localparam int ELEM_W = 16;

  // a single vector element
  typedef logic [ELEM_W-1:0] elem_t;

  // element index, one bit wider than needed for 0..VLMAX-1 so that vl = VLMAX fits
  typedef logic [$clog2(VLMAX+1)-1:0] offset_t;

  // vector register number
  typedef logic [$clog2(NUM_VREGS)-1:0] vreg_t;

  // one write enable per lane, bit i belongs to element offset+i
  typedef logic [NUM_LANES-1:0] lane_mask_t;

  // one element group, lane 0 sits in the low bits
  typedef logic [NUM_LANES*ELEM_W-1:0] group_t;

endpackage

`default_nettype wire

// ==== src/vec_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_issue (
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    clear,
  input  wire logic                    hold,
  input  wire logic                    start,
  input  wire vec_op_pkg::vec_op_e     op,
  input  wire vec_cfg_pkg::vreg_t      vd,
  input  wire vec_cfg_pkg::vreg_t      vs1,
  input  wire vec_cfg_pkg::vreg_t      vs2,
  input  wire vec_cfg_pkg::offset_t    vl,
  input  wire vec_cfg_pkg::offset_t    vstart,
  input  wire logic                    wb_last,
  output logic                         busy,
  output logic                         rd_valid,
  output logic                         rd_last,
  output vec_cfg_pkg::vreg_t           rd_vs1,
  output vec_cfg_pkg::vreg_t           rd_vs2,
  output vec_cfg_pkg::vreg_t           iss_vd,
  output vec_op_pkg::vec_op_e          iss_op,
  output vec_cfg_pkg::offset_t         rd_offset,
  output vec_cfg_pkg::lane_mask_t      rd_mask,
  output logic                         done
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  logic       accept;
  logic       empty;
  logic       empty_done;
  offset_t    vl_clamp;
  offset_t    vl_q;
  offset_t    cnt_vl;
  offset_t    cnt_offset;
  logic       cnt_last;
  logic       cnt_active;
  lane_mask_t grp_mask;

  // a start is only taken while no instruction is in flight
  assign accept   = start & ~busy;
  assign vl_clamp = (vl > offset_t'(VLMAX)) ? offset_t'(VLMAX) : vl;
  assign empty    = (vstart >= vl_clamp);

  // the counter needs the new length in the start cycle, before vl_q is loaded
  assign cnt_vl = accept ? vl_clamp : vl_q;

  element_counter i_element_counter (
    .CLK     (CLK),
    .nRST    (nRST),
    .clear   (clear),
    .start   (accept),
    .advance (~hold),
    .vl      (cnt_vl),
    .vstart  (vstart),
    .offset  (cnt_offset),
    .last    (cnt_last),
    .active  (cnt_active)
  );

  // lane i is live while its element index stays below vl
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      grp_mask[i] = ({1'b0, cnt_offset} + ($bits(offset_t)+1)'(i)) < {1'b0, vl_q};
    end
  end

  // instruction fields stay fixed for the whole instruction
  always_ff @(posedge CLK) begin
    if (accept) begin
      iss_op <= op;
      iss_vd <= vd;
      rd_vs1 <= vs1;
      rd_vs2 <= vs2;
      vl_q   <= vl_clamp;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      busy       <= 1'b0;
      empty_done <= 1'b0;
    end else if (clear) begin
      busy       <= 1'b0;
      empty_done <= 1'b0;
    end else begin
      // an empty instruction finishes without ever raising busy
      empty_done <= accept & empty;
      if (accept && !empty) begin
        busy <= 1'b1;
      end else if (wb_last) begin
        busy <= 1'b0;
      end
    end
  end

  // the group held by the counter goes out one cycle later
  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end else if (clear) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end else if (!hold) begin
      rd_valid <= cnt_active;
      rd_last  <= cnt_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (!hold) begin
      rd_offset <= cnt_offset;
      rd_mask   <= grp_mask;
    end
  end

  assign done = wb_last | empty_done;

endmodule

`default_nettype wire

// ==== src/vec_lane_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_lane_alu (
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    hold,
  input  wire logic                    clear,
  input  wire logic                    ex_valid,
  input  wire logic                    ex_last,
  input  wire vec_cfg_pkg::group_t     ex_a,
  input  wire vec_cfg_pkg::group_t     ex_b,
  input  wire vec_cfg_pkg::offset_t    ex_offset,
  input  wire vec_cfg_pkg::lane_mask_t ex_mask,
  input  wire vec_op_pkg::vec_op_e     iss_op,
  input  wire vec_cfg_pkg::vreg_t      iss_vd,
  output logic                         wb_en,
  output logic                         wb_last,
  output vec_cfg_pkg::vreg_t           wb_reg,
  output vec_cfg_pkg::offset_t         wb_offset,
  output vec_cfg_pkg::group_t          wb_data,
  output vec_cfg_pkg::lane_mask_t      wb_mask
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  group_t result;
  logic   wb_valid;
  logic   wb_last_q;

  // every lane computes, masked lanes are only kept out of the write
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      result[i*ELEM_W +: ELEM_W] = vec_elem_op(iss_op,
                                               elem_t'(ex_a[i*ELEM_W +: ELEM_W]),
                                               elem_t'(ex_b[i*ELEM_W +: ELEM_W]));
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      wb_valid  <= 1'b0;
      wb_last_q <= 1'b0;
    end else if (clear) begin
      wb_valid  <= 1'b0;
      wb_last_q <= 1'b0;
    end else if (!hold) begin
      wb_valid  <= ex_valid;
      wb_last_q <= ex_last;
    end
  end

  always_ff @(posedge CLK) begin
    if (!hold) begin
      wb_reg    <= iss_vd;
      wb_offset <= ex_offset;
      wb_data   <= result;
      wb_mask   <= ex_mask;
    end
  end

  // a held group waits in the register and is written once hold drops
  assign wb_en   = wb_valid & ~hold;
  assign wb_last = wb_en & wb_last_q;

endmodule

`default_nettype wire

// ==== src/vec_op_pkg.sv ====
`default_nettype none

package vec_op_pkg;

  // vector integer operations carried by an instruction
  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4,
    VMIN = 3'd5
  } vec_op_e;

  // element level result of an operation
  // sums and differences wrap around at the element width
  // VMIN compares both operands as unsigned numbers
  function automatic vec_cfg_pkg::elem_t vec_elem_op(vec_op_e op,
                                                     vec_cfg_pkg::elem_t a,
                                                     vec_cfg_pkg::elem_t b);
    vec_cfg_pkg::elem_t res;
    case (op)
      VADD: res = a + b;
      VSUB: res = a - b;
      VAND: res = a & b;
      VOR:  res = a | b;
      VXOR: res = a ^ b;
      VMIN: res = (a < b) ? a : b;
      // encodings 6 and 7 are unused, pass the first operand through
      default: res = a;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== src/vec_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_regfile (
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    hold,
  input  wire logic                    clear,
  input  wire logic                    rd_valid,
  input  wire logic                    rd_last,
  input  wire vec_cfg_pkg::vreg_t      rd_vs1,
  input  wire vec_cfg_pkg::vreg_t      rd_vs2,
  input  wire vec_cfg_pkg::offset_t    rd_offset,
  input  wire vec_cfg_pkg::lane_mask_t rd_mask,
  input  wire logic                    wr_en,
  input  wire vec_cfg_pkg::vreg_t      wr_reg,
  input  wire vec_cfg_pkg::offset_t    wr_offset,
  input  wire vec_cfg_pkg::group_t     wr_data,
  input  wire vec_cfg_pkg::lane_mask_t wr_mask,
  input  wire logic                    load_en,
  input  wire vec_cfg_pkg::vreg_t      load_reg,
  input  wire vec_cfg_pkg::offset_t    load_index,
  input  wire vec_cfg_pkg::group_t     load_data,
  output logic                         ex_valid,
  output logic                         ex_last,
  output vec_cfg_pkg::group_t          ex_a,
  output vec_cfg_pkg::group_t          ex_b,
  output vec_cfg_pkg::offset_t         ex_offset,
  output vec_cfg_pkg::lane_mask_t      ex_mask
);
  import vec_cfg_pkg::*;

  elem_t  mem [NUM_VREGS][VLMAX];
  group_t grp_a;
  group_t grp_b;
  logic   wr_go;

  // element slot of a lane, an odd vstart can push the last lane past VLMAX
  // and that lane is always masked off, so the index simply wraps
  function automatic logic [$clog2(VLMAX)-1:0] elem_idx(offset_t base, int unsigned lane);
    offset_t pos;
    pos = base + offset_t'(lane);
    return pos[$clog2(VLMAX)-1:0];
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      grp_a[i*ELEM_W +: ELEM_W] = mem[rd_vs1][elem_idx(rd_offset, i)];
      grp_b[i*ELEM_W +: ELEM_W] = mem[rd_vs2][elem_idx(rd_offset, i)];
    end
  end

  // a preload wins over a write-back aimed at the same register
  assign wr_go = wr_en & ~(load_en & (load_reg == wr_reg));

  // reads in the same cycle still see the old contents
  always_ff @(posedge CLK) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wr_go && wr_mask[i]) begin
        mem[wr_reg][elem_idx(wr_offset, i)] <= wr_data[i*ELEM_W +: ELEM_W];
      end
      if (load_en) begin
        mem[load_reg][elem_idx(load_index, i)] <= load_data[i*ELEM_W +: ELEM_W];
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      ex_valid <= 1'b0;
      ex_last  <= 1'b0;
    end else if (clear) begin
      ex_valid <= 1'b0;
      ex_last  <= 1'b0;
    end else if (!hold) begin
      ex_valid <= rd_valid;
      ex_last  <= rd_last;
    end
  end

  // operands and group tags move together into the execute stage
  always_ff @(posedge CLK) begin
    if (!hold) begin
      ex_a      <= grp_a;
      ex_b      <= grp_b;
      ex_offset <= rd_offset;
      ex_mask   <= rd_mask;
    end
  end

endmodule

`default_nettype wire

// ==== src/vec_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vec_unit_top (
  input  wire logic                    CLK,
  input  wire logic                    nRST,
  input  wire logic                    start,
  input  wire logic                    hold,
  input  wire logic                    clear,
  input  wire vec_op_pkg::vec_op_e     op,
  input  wire vec_cfg_pkg::vreg_t      vd,
  input  wire vec_cfg_pkg::vreg_t      vs1,
  input  wire vec_cfg_pkg::vreg_t      vs2,
  input  wire vec_cfg_pkg::offset_t    vl,
  input  wire vec_cfg_pkg::offset_t    vstart,
  input  wire logic                    load_en,
  input  wire vec_cfg_pkg::vreg_t      load_reg,
  input  wire vec_cfg_pkg::offset_t    load_index,
  input  wire vec_cfg_pkg::group_t     load_data,
  output logic                         busy,
  output logic                         done,
  output logic                         wb_en,
  output vec_cfg_pkg::vreg_t           wb_reg,
  output vec_cfg_pkg::offset_t         wb_offset,
  output vec_cfg_pkg::group_t          wb_data,
  output vec_cfg_pkg::lane_mask_t      wb_mask
);
  import vec_cfg_pkg::*;
  import vec_op_pkg::*;

  // issue to register file
  logic       rd_valid;
  logic       rd_last;
  vreg_t      rd_vs1;
  vreg_t      rd_vs2;
  offset_t    rd_offset;
  lane_mask_t rd_mask;

  // register file to execute, with the instruction fields from issue
  logic       ex_valid;
  logic       ex_last;
  group_t     ex_a;
  group_t     ex_b;
  offset_t    ex_offset;
  lane_mask_t ex_mask;
  vec_op_e    iss_op;
  vreg_t      iss_vd;

  // last group leaving the execute stage, closes the instruction
  logic       wb_last;

  vec_issue i_vec_issue (
    .CLK(CLK), .nRST(nRST), .clear(clear), .hold(hold), .start(start),
    .op(op), .vd(vd), .vs1(vs1), .vs2(vs2), .vl(vl), .vstart(vstart),
    .wb_last(wb_last), .busy(busy), .rd_valid(rd_valid), .rd_last(rd_last),
    .rd_vs1(rd_vs1), .rd_vs2(rd_vs2), .iss_vd(iss_vd), .iss_op(iss_op),
    .rd_offset(rd_offset), .rd_mask(rd_mask), .done(done)
  );

  vec_regfile i_vec_regfile (
    .CLK(CLK), .nRST(nRST), .hold(hold), .clear(clear),
    .rd_valid(rd_valid), .rd_last(rd_last), .rd_vs1(rd_vs1), .rd_vs2(rd_vs2),
    .rd_offset(rd_offset), .rd_mask(rd_mask),
    .wr_en(wb_en), .wr_reg(wb_reg), .wr_offset(wb_offset), .wr_data(wb_data),
    .wr_mask(wb_mask), .load_en(load_en), .load_reg(load_reg),
    .load_index(load_index), .load_data(load_data),
    .ex_valid(ex_valid), .ex_last(ex_last), .ex_a(ex_a), .ex_b(ex_b),
    .ex_offset(ex_offset), .ex_mask(ex_mask)
  );

  vec_lane_alu i_vec_lane_alu (
    .CLK(CLK), .nRST(nRST), .hold(hold), .clear(clear),
    .ex_valid(ex_valid), .ex_last(ex_last), .ex_a(ex_a), .ex_b(ex_b),
    .ex_offset(ex_offset), .ex_mask(ex_mask), .iss_op(iss_op), .iss_vd(iss_vd),
    .wb_en(wb_en), .wb_last(wb_last), .wb_reg(wb_reg), .wb_offset(wb_offset),
    .wb_data(wb_data), .wb_mask(wb_mask)
  );

endmodule

`default_nettype wire
